/* bench/timerModel.svh */
`ifndef TIMER_MODEL_SVH
`define TIMER_MODEL_SVH

// Reference model of the counter channels, stepped once per clk edge
modeT mCtrl [numChannels];
countT mInit [numChannels];
countT mCount [numChannels];
countT mLatch [numChannels];
int mEdges [numChannels];
logic [numChannels-1:0] mLatched;
logic [numChannels-1:0] mToggle;
logic [numChannels-1:0] mEnabled;
logic [numChannels-1:0] mLoaded;
logic [numChannels-1:0] mFirst;
logic [numChannels-1:0] mDone;
logic [numChannels-1:0] mOut;
logic [numChannels-1:0] mCPrev;
logic [numChannels-1:0] mGateS;
logic [numChannels-1:0] mGatePrev;
logic [numChannels-1:0] mRdPrev;
logic [numChannels-1:0] mWePrev;

function automatic int toValue(input countT code, input logic bcd);
	if (!bcd)
		return int'(code);
	return int'(code[15:12]) * 1000 + int'(code[11:8]) * 100 + int'(code[7:4]) * 10
		+ int'(code[3:0]);
endfunction

function automatic countT toCode(input int v, input logic bcd);
	if (!bcd)
		return countT'(v);
	return {4'(v / 1000 % 10), 4'(v / 100 % 10), 4'(v / 10 % 10), 4'(v % 10)};
endfunction

// Square wave mode takes two per edge, except the first edge of an odd count
function automatic countT nextCount(input int n);
	logic sq;
	int modulus;
	int v;
	countT code;
	sq = mCtrl[n][2:1] == 2'b11;
	modulus = mCtrl[n][0] ? 10000 : 65536;
	v = toValue(mCount[n], mCtrl[n][0]);
	v = (v - ((sq && !mFirst[n]) ? 2 : 1) + modulus) % modulus;
	code = toCode(v, mCtrl[n][0]);
	if (sq)
		code[0] = 1'b0;
	return code;
endfunction

function automatic dataT modelByte(input int n);
	countT value;
	value = mLatched[n] ? mLatch[n] : mCount[n];
	return mToggle[n] ? value[15:8] : value[7:0];
endfunction

task automatic resetChannel(input int n);
	mCtrl[n] = resetMode;
	mInit[n] = '0;
	mCount[n] = '0;
	mLatch[n] = '0;
	{mLatched[n], mToggle[n], mEnabled[n], mLoaded[n], mFirst[n]} = 5'b0;
	{mDone[n], mOut[n], mCPrev[n], mGateS[n], mGatePrev[n]} = 5'b10000;
	mRdPrev[n] = 1'b0;
	mWePrev[n] = 1'b1;
endtask

task automatic stepChannel(input int n, input logic cIn, input logic gIn, input logic rdIn,
		input logic weIn, input logic ctrl, input dataT d);
	logic [2:0] md;
	accessT acc;
	countT nxt;
	countT oCount;
	logic oOut;
	logic oDone;
	logic oToggle;
	logic rDone;
	logic wStart;
	md = mCtrl[n][3:1];
	acc = accessT'(mCtrl[n][5:4]);
	oCount = mCount[n];
	oOut = mOut[n];
	oDone = mDone[n];
	oToggle = mToggle[n];
	nxt = nextCount(n);
	rDone = mRdPrev[n] && !rdIn;
	wStart = mWePrev[n] && !weIn;
	if (cIn && !mCPrev[n]) begin
		mEdges[n]++;
		if (mEnabled[n] && mLoaded[n]) begin
			if (md[1] && nxt == '0) begin
				mCount[n] = mInit[n];
				mFirst[n] = mInit[n][0] && !oOut;
			end else begin
				mCount[n] = nxt;
				mFirst[n] = 1'b0;
			end
			if (nxt <= 16'd1 && !oDone) begin
				case (md)
					3'd0, 3'd1: begin
						if (nxt == '0) begin
							mOut[n] = 1'b1;
							mDone[n] = 1'b1;
						end
					end
					3'd2: mOut[n] = nxt == '0;
					3'd3: mOut[n] = !oOut;
					default: begin
						mOut[n] = nxt == '0;
						mDone[n] = nxt == '0;
					end
				endcase
			end
		end else if (mEnabled[n]) begin
			mCount[n] = mInit[n];
			mLoaded[n] = 1'b1;
			mFirst[n] = 1'b1;
			mDone[n] = 1'b0;
			if (md[2:1] == 2'b00)
				mOut[n] = 1'b0;
		end
	end
	// Gate enables counting, or retriggers in modes 1 and 5
	if (mGateS[n] != mGatePrev[n]) begin
		if (md[1:0] != 2'b01) begin
			mEnabled[n] = mGateS[n];
		end else if (mGateS[n]) begin
			mLoaded[n] = 1'b0;
			mEnabled[n] = 1'b1;
		end
	end
	if (rDone) begin
		if (acc == lsbMsb)
			mToggle[n] = !oToggle;
		if (acc != lsbMsb || oToggle)
			mLatched[n] = 1'b0;
	end else if (wStart && ctrl) begin
		if (d[5:4] == 2'b00) begin
			mLatched[n] = 1'b1;
			mToggle[n] = acc == msbOnly;
			mLatch[n] = oCount;
		end else begin
			mCtrl[n] = d[5:0];
			{mEnabled[n], mLoaded[n], mDone[n], mLatched[n]} = 4'b0010;
			mToggle[n] = d[5:4] == 2'b10;
			mOut[n] = d[3:1] != 3'd0;
		end
	end else if (wStart) begin
		if (md[1:0] != 2'b01)
			mEnabled[n] = mGateS[n] && (acc != lsbMsb || oToggle);
		mToggle[n] = acc == msbOnly || (acc == lsbMsb && !oToggle);
		mLoaded[n] = md[1:0] != 2'b00 && !oDone;
		if (oDone || md == 3'd0)
			mOut[n] = md != 3'd0;
		case (acc)
			lsbOnly: mInit[n] = {8'h00, d};
			msbOnly: mInit[n] = {d, 8'h00};
			lsbMsb: begin
				if (oToggle)
					mInit[n][15:8] = d;
				else
					mInit[n][7:0] = d;
			end
			default: ;
		endcase
	end
	mCPrev[n] = cIn;
	mGatePrev[n] = mGateS[n];
	mGateS[n] = gIn;
	mRdPrev[n] = rdIn;
	mWePrev[n] = weIn;
endtask

`endif

/* bench/tbIntervalTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module tbIntervalTimer
	import timerPkg::*, busPkg::*;
();

	localparam int numTests = 24;
	localparam int maxHalf = 10;
	localparam longint maxPeriodNs = 2 * maxHalf * 40;

	logic clk = 1'b0;
	logic rst;
	logic cs_n;
	logic rd;
	logic we_n;
	addrT addr;
	dataT wrData;
	dataT rdData;
	logic [numChannels-1:0] cClk;
	logic [numChannels-1:0] gateIn;
	logic out0;
	logic out1;
	logic out2;
	int halfPeriod [numChannels];
	int halfLeft [numChannels];
	int tCh [numTests];
	int tMode [numTests];
	int tAcc [numTests];
	int tBcd [numTests];
	int tCount [numTests];
	longint limitNs = 0;

	`include "timerModel.svh"

	intervalTimer dut_i (
		.clk(clk), .rst(rst), .cs_n(cs_n), .rd(rd), .we_n(we_n), .addr(addr),
		.wrData(wrData), .rdData(rdData), .c0(cClk[0]), .c1(cClk[1]), .c2(cClk[2]),
		.gate0(gateIn[0]), .gate1(gateIn[1]), .gate2(gateIn[2]),
		.out0(out0), .out1(out1), .out2(out2)
	);

	always #20 clk = !clk;

	task automatic checkEqual(input string name, input countT actual, input countT expected);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// Channel n sees the access when the address or the control word select names it
	function automatic logic targets(input int n);
		if (cs_n)
			return 1'b0;
		if (addr == controlAddr)
			return wrData[7:6] == 2'(n);
		return addr == 2'(n);
	endfunction

	always @(posedge clk) begin
		for (int n = 0; n < numChannels; n++) begin
			if (rst)
				resetChannel(n);
			else
				stepChannel(n, cClk[n], gateIn[n], targets(n) && rd && addr != controlAddr,
					!(targets(n) && !we_n), addr == controlAddr, wrData);
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			checkEqual("out0", 16'(out0), 16'(mOut[0]));
			checkEqual("out1", 16'(out1), 16'(mOut[1]));
			checkEqual("out2", 16'(out2), 16'(mOut[2]));
		end
	end

	// Each count clock is a square wave with a half period of its own
	initial begin
		cClk = '0;
		halfLeft = '{default: 0};
		forever begin
			@(posedge clk);
			#2;
			for (int n = 0; n < numChannels; n++) begin
				if (halfLeft[n] <= 1) begin
					cClk[n] = !cClk[n];
					halfLeft[n] = halfPeriod[n];
				end else begin
					halfLeft[n]--;
				end
			end
		end
	end

	initial begin
		wait (limitNs != 0);
		#(limitNs);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Verification failed");
		$fatal(1);
	end

	task automatic cycles(input int k);
		repeat (k) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic waitEdges(input int ch, input int k);
		int target;
		target = mEdges[ch] + k;
		while (mEdges[ch] < target)
			cycles(1);
	endtask

	task automatic writeReg(input addrT a, input dataT d);
		cs_n = 1'b0;
		addr = a;
		wrData = d;
		we_n = 1'b0;
		cycles(2);
		we_n = 1'b1;
		cycles(2);
		cs_n = 1'b1;
	endtask

	task automatic readReg(input addrT a, output dataT d);
		cs_n = 1'b0;
		addr = a;
		rd = 1'b1;
		cycles(1);
		@(negedge clk);
		d = rdData;
		checkEqual("rdData", 16'(rdData), 16'(modelByte(int'(a))));
		@(posedge clk);
		#2;
		rd = 1'b0;
		cycles(2);
		cs_n = 1'b1;
	endtask

	task automatic readCount(input int ch, input accessT acc, output countT value);
		dataT lo;
		dataT hi;
		readReg(addrT'(ch), lo);
		value = (acc == msbOnly) ? {lo, 8'h00} : {8'h00, lo};
		if (acc == lsbMsb) begin
			readReg(addrT'(ch), hi);
			value = {hi, lo};
		end
	endtask

	function automatic countT encodeCount(input int v, input logic bcd);
		return bcd ? {8'h00, 4'(v / 10), 4'(v % 10)} : countT'(v);
	endfunction

	task automatic runTest(input int t);
		int ch;
		int other;
		logic bcd;
		accessT acc;
		countT cnt;
		countT v1;
		countT v2;
		ch = tCh[t];
		bcd = tBcd[t] != 0;
		acc = accessT'(tAcc[t]);
		cnt = encodeCount(tCount[t], bcd);
		other = (ch + 1) % numChannels;
		gateIn[ch] = !(tMode[t] == 1 || tMode[t] == 5);
		writeReg(controlAddr, {selectT'(ch), acc, modeFieldT'(tMode[t]), bcd});
		// A control word to a neighbour must leave this channel alone
		writeReg(controlAddr, {selectT'(other), lsbOnly, 3'd2, 1'b0});
		writeReg(addrT'(other), 8'd5);
		writeReg(addrT'(ch), cnt[7:0]);
		if (acc == lsbMsb)
			writeReg(addrT'(ch), cnt[15:8]);
		if (tMode[t] == 1 || tMode[t] == 5) begin
			waitEdges(ch, 2);
			gateIn[ch] = 1'b1;
			cycles(2);
			gateIn[ch] = 1'b0;
		end
		waitEdges(ch, 3);
		writeReg(controlAddr, {selectT'(ch), 6'b000000});
		// The counter keeps running while the latched value waits to be read
		waitEdges(ch, 2);
		readCount(ch, acc, v1);
		if (bcd) begin
			for (int i = 0; i < 4; i++)
				checkEqual("BCD digit in range", 16'(v1[4 * i +: 4] <= 4'd9), 16'd1);
		end
		if (tMode[t] == 1 || tMode[t] == 5) begin
			// Another rising gate edge restarts the count
			gateIn[ch] = 1'b1;
			cycles(2);
			gateIn[ch] = 1'b0;
		end
		if (tMode[t] == 0 || tMode[t] == 2 || tMode[t] == 4) begin
			gateIn[ch] = 1'b0;
			waitEdges(ch, 2);
			readCount(ch, acc, v1);
			waitEdges(ch, 1);
			readCount(ch, acc, v2);
			checkEqual("held count", v2, v1);
			gateIn[ch] = 1'b1;
		end
		waitEdges(ch, 2 * tCount[t] + 4);
	endtask

	initial begin
		longint total;
		void'($urandom(48));
		rst = 1'b1;
		cs_n = 1'b1;
		rd = 1'b0;
		we_n = 1'b1;
		addr = '0;
		wrData = '0;
		gateIn = '0;
		total = 0;
		for (int n = 0; n < numChannels; n++)
			halfPeriod[n] = int'($urandom_range(4, maxHalf));
		for (int t = 0; t < numTests; t++) begin
			tCh[t] = int'($urandom_range(0, numChannels - 1));
			tMode[t] = int'($urandom_range(0, 5));
			tAcc[t] = int'($urandom_range(1, 3));
			tBcd[t] = int'($urandom_range(0, 1));
			tCount[t] = int'($urandom_range(2, 40));
			total += longint'(tCount[t]) * 2 * maxPeriodNs + 20 * maxPeriodNs;
		end
		limitNs = total + 2000;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int t = 0; t < numTests; t++)
			runTest(t);
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
rtl/timerPkg.sv
rtl/busPkg.sv
rtl/timerChannel.sv
rtl/timerBusInterface.sv
rtl/intervalTimer.sv
bench/tbIntervalTimer.sv

/* rtl/busPkg.sv */
`default_nettype none

package busPkg;

	// One byte on the CPU data bus
	typedef logic [7:0] dataT;

	// Register address, channels 0 to 2 plus the control register
	typedef logic [1:0] addrT;

	localparam addrT controlAddr = 2'd3;

endpackage

`default_nettype wire

/* rtl/intervalTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module intervalTimer
	import timerPkg::*, busPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic cs_n,
	input  logic rd,
	input  logic we_n,
	input  addrT addr,
	input  dataT wrData,
	output dataT rdData,
	input  logic c0,
	input  logic c1,
	input  logic c2,
	input  logic gate0,
	input  logic gate1,
	input  logic gate2,
	output logic out0,
	output logic out1,
	output logic out2
);

	logic [numChannels-1:0] chAddr;
	logic [numChannels-1:0] chRd;
	logic [numChannels-1:0] chWe_n;
	dataT chRdData0;
	dataT chRdData1;
	dataT chRdData2;

	timerBusInterface busIf_i (
		.cs_n(cs_n),
		.rd(rd),
		.we_n(we_n),
		.addr(addr),
		.wrData(wrData),
		.chRdData0(chRdData0),
		.chRdData1(chRdData1),
		.chRdData2(chRdData2),
		.chAddr(chAddr),
		.chRd(chRd),
		.chWe_n(chWe_n),
		.rdData(rdData)
	);

	timerChannel channel0_i (
		.clk(clk),
		.rst(rst),
		.countClk(c0),
		.gate(gate0),
		.out(out0),
		.chAddr(chAddr[0]),
		.rd(chRd[0]),
		.we_n(chWe_n[0]),
		.wrData(wrData),
		.rdData(chRdData0)
	);

	timerChannel channel1_i (
		.clk(clk),
		.rst(rst),
		.countClk(c1),
		.gate(gate1),
		.out(out1),
		.chAddr(chAddr[1]),
		.rd(chRd[1]),
		.we_n(chWe_n[1]),
		.wrData(wrData),
		.rdData(chRdData1)
	);

	timerChannel channel2_i (
		.clk(clk),
		.rst(rst),
		.countClk(c2),
		.gate(gate2),
		.out(out2),
		.chAddr(chAddr[2]),
		.rd(chRd[2]),
		.we_n(chWe_n[2]),
		.wrData(wrData),
		.rdData(chRdData2)
	);

endmodule

`default_nettype wire

/* rtl/timerBusInterface.sv */
`timescale 1ns/1ps
`default_nettype none

module timerBusInterface
	import timerPkg::*, busPkg::*;
(
	input  logic cs_n,
	input  logic rd,
	input  logic we_n,
	input  addrT addr,
	input  dataT wrData,
	input  dataT chRdData0,
	input  dataT chRdData1,
	input  dataT chRdData2,
	output logic [numChannels-1:0] chAddr,
	output logic [numChannels-1:0] chRd,
	output logic [numChannels-1:0] chWe_n,
	output dataT rdData
);

	logic isControl;
	selectT ctrlSelect;
	logic [numChannels-1:0] hit;

	assign isControl = addr == controlAddr;
	assign ctrlSelect = wrData[7:6];

	// Control words go to the channel named in their select field,
	// select value 3 matches no channel and is dropped
	always_comb begin
		for (int n = 0; n < numChannels; n++) begin
			if (isControl)
				hit[n] = !cs_n && ctrlSelect == selectT'(n);
			else
				hit[n] = !cs_n && addr == addrT'(n);
		end
	end

	assign chAddr = {numChannels{isControl}};

	// The control register cannot be read
	assign chRd = hit & {numChannels{rd && !isControl}};
	assign chWe_n = ~(hit & {numChannels{!we_n}});

	always_comb begin
		rdData = '0;
		if (!isControl) begin
			case (addr)
				addrT'(0): rdData = chRdData0;
				addrT'(1): rdData = chRdData1;
				addrT'(2): rdData = chRdData2;
				default: rdData = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/timerChannel.sv */
`timescale 1ns/1ps
`default_nettype none

module timerChannel
	import timerPkg::*, busPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic countClk,
	input  logic gate,
	output logic out,
	input  logic chAddr,
	input  logic rd,
	input  logic we_n,
	input  dataT wrData,
	output dataT rdData
);

	modeT modeQ;
	countT initQ;
	countT latchQ;
	countT counterQ;
	countT step1;
	countT step2;
	countT nextSum;
	countT nextCount;
	countT readValue;
	accessT access;
	accessT wrAccess;
	modeFieldT modeSel;
	logic bcd;
	logic squareWave;
	logic triggered;
	logic enabled;
	logic loaded;
	logic latched;
	logic byteToggle;
	logic firstStep;
	logic done;
	logic cPrev;
	logic gateS;
	logic gatePrev;
	logic rdPrev;
	logic weNPrev;
	logic countEdge;
	logic gateChange;
	logic readDone;
	logic writeStart;

	assign access = accessT'(modeQ[5:4]);
	assign modeSel = modeQ[3:1];
	assign bcd = modeQ[0];
	assign wrAccess = accessT'(wrData[5:4]);
	assign squareWave = modeSel[1:0] == 2'b11;
	// Modes 1 and 5 start on a rising gate edge
	assign triggered = modeSel[1:0] == 2'b01;

	assign countEdge = countClk && !cPrev;
	assign gateChange = gateS != gatePrev;
	assign readDone = rdPrev && !rd;
	assign writeStart = weNPrev && !we_n;

	// In BCD the correction term borrows across every zero digit
	always_comb begin
		step1 = 16'hFFFF;
		if (bcd) begin
			if (counterQ[3:0] != 4'h0)
				step1 = 16'hFFFF;
			else if (counterQ[7:4] != 4'h0)
				step1 = 16'hFFF9;
			else if (counterQ[11:8] != 4'h0)
				step1 = 16'hFF99;
			else if (counterQ[15:12] != 4'h0)
				step1 = 16'hF999;
			else
				step1 = 16'h9999;
		end
	end

	always_comb begin
		step2 = 16'hFFFE;
		if (bcd) begin
			if (counterQ[3:1] != 3'd0)
				step2 = 16'hFFFE;
			else if (counterQ[7:4] != 4'h0)
				step2 = 16'hFFF8;
			else if (counterQ[11:8] != 4'h0)
				step2 = 16'hFF98;
			else if (counterQ[15:12] != 4'h0)
				step2 = 16'hF998;
			else
				step2 = 16'h9998;
		end
	end

	// Square wave counts by two, the first step of an odd count takes one
	assign nextSum = counterQ + ((firstStep || !squareWave) ? step1 : step2);
	assign nextCount = {nextSum[15:1], nextSum[0] && !squareWave};

	assign readValue = latched ? latchQ : counterQ;
	assign rdData = byteToggle ? readValue[15:8] : readValue[7:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			modeQ <= resetMode;
			counterQ <= '0;
			enabled <= 1'b0;
			loaded <= 1'b0;
			latched <= 1'b0;
			byteToggle <= 1'b0;
			firstStep <= 1'b0;
			done <= 1'b1;
			out <= 1'b0;
			cPrev <= 1'b0;
			gateS <= 1'b0;
			gatePrev <= 1'b0;
			rdPrev <= 1'b0;
			weNPrev <= 1'b1;
		end else begin
			cPrev <= countClk;
			gateS <= gate;
			gatePrev <= gateS;
			rdPrev <= rd;
			weNPrev <= we_n;

			if (enabled && countEdge) begin
				if (loaded) begin
					if (modeSel[1] && nextCount == '0) begin
						counterQ <= initQ;
						firstStep <= initQ[0] && !out;
					end else begin
						counterQ <= nextCount;
						firstStep <= 1'b0;
					end
					if (nextCount[15:1] == '0 && !done) begin
						case (modeSel)
							3'd0, 3'd1: begin
								if (!nextCount[0]) begin
									out <= 1'b1;
									done <= 1'b1;
								end
							end
							3'd2, 3'd6: out <= !nextCount[0];
							3'd3, 3'd7: out <= !out;
							default: begin
								if (nextCount[0]) begin
									out <= 1'b0;
								end else begin
									out <= 1'b1;
									done <= 1'b1;
								end
							end
						endcase
					end
				end else begin
					counterQ <= initQ;
					loaded <= 1'b1;
					firstStep <= 1'b1;
					done <= 1'b0;
					if (modeSel[2:1] == 2'b00)
						out <= 1'b0;
				end
			end

			if (gateChange) begin
				if (!triggered) begin
					enabled <= gateS;
				end else if (gateS) begin
					loaded <= 1'b0;
					enabled <= 1'b1;
				end
			end

			if (readDone) begin
				if (access == lsbMsb)
					byteToggle <= !byteToggle;
				if (access != lsbMsb || byteToggle)
					latched <= 1'b0;
			end else if (writeStart) begin
				if (chAddr) begin
					if (wrAccess == latchCmd) begin
						latched <= 1'b1;
						byteToggle <= access == msbOnly;
					end else begin
						modeQ <= wrData[5:0];
						enabled <= 1'b0;
						loaded <= 1'b0;
						done <= 1'b1;
						latched <= 1'b0;
						byteToggle <= wrAccess == msbOnly;
						out <= wrData[3:1] != 3'd0;
					end
				end else begin
					// A running periodic or one-shot count picks up the new value later
					if (!triggered)
						enabled <= gateS && (access != lsbMsb || byteToggle);
					byteToggle <= access == msbOnly || (access == lsbMsb && !byteToggle);
					loaded <= modeSel[1:0] != 2'b00 && !done;
					if (done || modeSel == 3'd0)
						out <= modeSel != 3'd0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (writeStart && !readDone) begin
			if (chAddr) begin
				if (wrAccess == latchCmd)
					latchQ <= counterQ;
			end else begin
				case (access)
					lsbOnly: initQ <= {8'h00, wrData};
					msbOnly: initQ <= {wrData, 8'h00};
					lsbMsb: begin
						if (byteToggle)
							initQ[15:8] <= wrData;
						else
							initQ[7:0] <= wrData;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/timerPkg.sv */
`default_nettype none

package timerPkg;

	// Three identical counter channels share the CPU bus
	localparam int numChannels = 3;

	// Counter value, initial count and latched count
	typedef logic [15:0] countT;

	// Low six bits of a control word: access field [5:4], mode [3:1], BCD [0]
	typedef logic [5:0] modeT;

	// Counter mode number, 0 to 5 (6 and 7 alias 2 and 3)
	typedef logic [2:0] modeFieldT;

	// Channel select field of a control word, value 3 is not a channel
	typedef logic [1:0] selectT;

	// Access field of a control word
	typedef enum logic [1:0] {
		latchCmd = 2'b00,
		lsbOnly  = 2'b01,
		msbOnly  = 2'b10,
		lsbMsb   = 2'b11
	} accessT;

	// State after reset matches a mode 0 control word with LSB access
	localparam modeT resetMode = {lsbOnly, 3'd0, 1'b0};

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run with Verilator, pass only when the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module tbIntervalTimer -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "Verification passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
